/* Bender.yml */
package:
  name: cpu_mem

export_include_dirs:
  - include

sources:
  # RTL in compile order
  - source/cpu_mem_pkg.sv
  - source/cache_array.sv
  - source/data_align.sv
  - source/mem_port.sv
  - source/cache_ctrl.sv
  - source/cpu_mem_top.sv
  - target: test
    files:
      - testbench/tb_cpu_mem.sv

/* cpu_mem.f */
+incdir+include
source/cpu_mem_pkg.sv
source/cache_array.sv
source/data_align.sv
source/mem_port.sv
source/cache_ctrl.sv
source/cpu_mem_top.sv
testbench/tb_cpu_mem.sv

/* include/cpu_mem_params.svh */
`ifndef CPU_MEM_PARAMS_SVH
`define CPU_MEM_PARAMS_SVH

// bus widths seen by the core and the memory bus
`define CM_ADDR_W 32
`define CM_DATA_W 32

// 16 lines per cache, one word per line
`define CM_INDEX_W 4

// address bits left over after index and byte offset
`define CM_TAG_W (`CM_ADDR_W - `CM_INDEX_W - 2)

`endif

/* source/cache_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_mem_params.svh"

module cache_array (
  input  wire                         clk_i,
  input  wire                         rst_n_i,
  input  wire  [`CM_ADDR_W-1:0]       lookup_addr_i,
  input  wire  cpu_mem_pkg::fill_t    fill_i,
  output logic                        hit_o,
  output logic [`CM_DATA_W-1:0]       rdata_o
);

  localparam int LINES = 1 << `CM_INDEX_W;
  localparam int LANES = `CM_DATA_W / 8;

  logic [LINES-1:0]                 valid_q;
  logic [`CM_TAG_W-1:0]             tag_q  [LINES];
  logic [LANES-1:0][7:0]            data_q [LINES];

  logic [`CM_INDEX_W-1:0]           lk_index;
  logic [`CM_TAG_W-1:0]             lk_tag;

  // split the lookup address into index and tag
  assign lk_index = lookup_addr_i[`CM_INDEX_W+1:2];
  assign lk_tag   = lookup_addr_i[`CM_ADDR_W-1:`CM_INDEX_W+2];

  assign hit_o   = valid_q[lk_index] & (tag_q[lk_index] == lk_tag);
  assign rdata_o = data_q[lk_index]; // read data is the line itself

  // valid bits are the only state that needs clearing
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (fill_i.we) begin
      valid_q[fill_i.index] <= 1'b1;
    end
  end

  // tag and data lanes, written only under byte enables
  always_ff @(posedge clk_i) begin
    if (fill_i.we) begin
      tag_q[fill_i.index] <= fill_i.tag;
      for (int i = 0; i < LANES; i++) begin
        if (fill_i.be[i]) begin
          data_q[fill_i.index][i] <= fill_i.data[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_mem_params.svh"

module cache_ctrl (
  input  wire                           clk_i,
  input  wire                           rst_n_i,
  input  wire                           inst_req_i,
  input  wire  [`CM_ADDR_W-1:0]         inst_addr_i,
  input  wire  cpu_mem_pkg::core_req_t  data_i,
  input  wire                           i_hit_i,
  input  wire                           d_hit_i,
  input  wire  [`CM_DATA_W-1:0]         store_data_i,
  input  wire  [(`CM_DATA_W/8)-1:0]     be_i,
  input  wire                           port_done_i,
  input  wire  [`CM_DATA_W-1:0]         port_rdata_i,
  output cpu_mem_pkg::bus_req_t         bus_o,
  output cpu_mem_pkg::fill_t            i_fill_o,
  output cpu_mem_pkg::fill_t            d_fill_o,
  output logic                          inst_stall_o,
  output logic                          data_stall_o
);

  cpu_mem_pkg::ctrl_state_e state_q;
  cpu_mem_pkg::ctrl_state_e state_d;
  logic                     store_done_q; // write acked last cycle
  logic                     i_miss;
  logic                     d_store;
  logic                     d_miss;
  logic                     in_d_write;
  logic [`CM_ADDR_W-1:0]    i_word_addr;
  logic [`CM_ADDR_W-1:0]    d_word_addr;

  assign i_miss      = inst_req_i & ~i_hit_i;
  assign d_store     = data_i.req & data_i.we; // stores always go to the bus
  assign d_miss      = data_i.req & ~data_i.we & ~d_hit_i;
  assign in_d_write  = (state_q == cpu_mem_pkg::ST_D_WRITE);
  assign i_word_addr = {inst_addr_i[`CM_ADDR_W-1:2], 2'b00};
  assign d_word_addr = {data_i.addr[`CM_ADDR_W-1:2], 2'b00};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= cpu_mem_pkg::ST_IDLE;
      store_done_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      store_done_q <= in_d_write & port_done_i;
    end
  end

  // launch from idle, I side first
  always_comb begin
    state_d     = state_q;
    bus_o       = '0;
    bus_o.addr  = d_word_addr;
    bus_o.wdata = store_data_i;
    bus_o.be    = '1;
    case (state_q)
      cpu_mem_pkg::ST_IDLE: begin
        if (i_miss) begin
          bus_o.valid = 1'b1;
          bus_o.addr  = i_word_addr;
          state_d     = cpu_mem_pkg::ST_I_REFILL;
        end else if (d_store) begin
          bus_o.valid = 1'b1;
          bus_o.we    = 1'b1;
          bus_o.be    = be_i; // only the stored lanes
          state_d     = cpu_mem_pkg::ST_D_WRITE;
        end else if (d_miss) begin
          bus_o.valid = 1'b1;
          state_d     = cpu_mem_pkg::ST_D_REFILL;
        end
      end
      cpu_mem_pkg::ST_I_REFILL,
      cpu_mem_pkg::ST_D_REFILL,
      cpu_mem_pkg::ST_D_WRITE: begin
        if (port_done_i) begin
          state_d = cpu_mem_pkg::ST_RESUME;
        end
      end
      default: state_d = cpu_mem_pkg::ST_IDLE; // resume lasts one cycle
    endcase
  end

  // array write commands, issued in the ack cycle
  always_comb begin
    i_fill_o.we    = (state_q == cpu_mem_pkg::ST_I_REFILL) & port_done_i;
    i_fill_o.index = inst_addr_i[`CM_INDEX_W+1:2];
    i_fill_o.tag   = inst_addr_i[`CM_ADDR_W-1:`CM_INDEX_W+2];
    i_fill_o.data  = port_rdata_i;
    i_fill_o.be    = '1;

    // write-through merges into the line only on a hit
    d_fill_o.we    = port_done_i &
                     ((state_q == cpu_mem_pkg::ST_D_REFILL) | (in_d_write & d_hit_i));
    d_fill_o.index = data_i.addr[`CM_INDEX_W+1:2];
    d_fill_o.tag   = data_i.addr[`CM_ADDR_W-1:`CM_INDEX_W+2];
    d_fill_o.data  = in_d_write ? store_data_i : port_rdata_i;
    d_fill_o.be    = in_d_write ? be_i : '1;
  end

  // stalls follow the lookup when idle, the request otherwise
  always_comb begin
    if (state_q == cpu_mem_pkg::ST_IDLE) begin
      inst_stall_o = i_miss;
      data_stall_o = d_store | d_miss;
    end else begin
      inst_stall_o = inst_req_i;
      data_stall_o = data_i.req & ~store_done_q; // store completes after ack
    end
  end

endmodule

`default_nettype wire

/* source/cpu_mem_pkg.sv */
`default_nettype none

`include "cpu_mem_params.svh"

package cpu_mem_pkg;

  // encoding follows the load/store funct3 field
  typedef enum logic [2:0] {
    ACC_BYTE   = 3'b000,
    ACC_HALF   = 3'b001,
    ACC_WORD   = 3'b010,
    ACC_BYTE_U = 3'b100,
    ACC_HALF_U = 3'b101
  } access_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_I_REFILL,
    ST_D_REFILL,
    ST_D_WRITE,
    ST_RESUME
  } ctrl_state_e;

  typedef struct packed {
    logic                  req;
    logic                  we;
    access_e               acc;
    logic [`CM_ADDR_W-1:0] addr;
    logic [`CM_DATA_W-1:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic                      valid;
    logic                      we;
    logic [`CM_ADDR_W-1:0]     addr;
    logic [`CM_DATA_W-1:0]     wdata;
    logic [(`CM_DATA_W/8)-1:0] be;
  } bus_req_t;

  typedef struct packed {
    logic                      we;
    logic [`CM_INDEX_W-1:0]    index;
    logic [`CM_TAG_W-1:0]      tag;
    logic [`CM_DATA_W-1:0]     data;
    logic [(`CM_DATA_W/8)-1:0] be;
  } fill_t;

endpackage

`default_nettype wire

/* source/cpu_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_mem_params.svh"

module cpu_mem_top (
  input  wire                           clk_i,
  input  wire                           rst_n_i,
  // instruction port
  input  wire                           inst_req_i,
  input  wire  [`CM_ADDR_W-1:0]         inst_addr_i,
  output logic [`CM_DATA_W-1:0]         inst_rdata_o,
  output logic                          inst_stall_o,
  // data port
  input  wire  cpu_mem_pkg::core_req_t  data_i,
  output logic [`CM_DATA_W-1:0]         data_rdata_o,
  output logic                          data_stall_o,
  // memory bus
  output cpu_mem_pkg::bus_req_t         mem_o,
  input  wire  [`CM_DATA_W-1:0]         mem_rdata_i,
  input  wire                           mem_ack_i
);

  logic                       i_hit;
  logic                       d_hit;
  logic [`CM_DATA_W-1:0]      d_rdata;
  logic [`CM_DATA_W-1:0]      store_data;
  logic [(`CM_DATA_W/8)-1:0]  be;
  logic                       port_done;
  logic [`CM_DATA_W-1:0]      port_rdata;
  cpu_mem_pkg::bus_req_t      bus_req;
  cpu_mem_pkg::fill_t         i_fill;
  cpu_mem_pkg::fill_t         d_fill;

  cache_array u_icache (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .lookup_addr_i (inst_addr_i),
    .fill_i        (i_fill),
    .hit_o         (i_hit),
    .rdata_o       (inst_rdata_o)   // fetched word straight to the core
  );

  cache_array u_dcache (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .lookup_addr_i (data_i.addr),
    .fill_i        (d_fill),
    .hit_o         (d_hit),
    .rdata_o       (d_rdata)
  );

  data_align u_data_align (
    .acc_i        (data_i.acc),
    .addr_lo_i    (data_i.addr[1:0]),
    .wdata_i      (data_i.wdata),
    .raw_i        (d_rdata),
    .store_data_o (store_data),
    .be_o         (be),
    .load_data_o  (data_rdata_o)
  );

  cache_ctrl u_cache_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .inst_req_i   (inst_req_i),
    .inst_addr_i  (inst_addr_i),
    .data_i       (data_i),
    .i_hit_i      (i_hit),
    .d_hit_i      (d_hit),
    .store_data_i (store_data),
    .be_i         (be),
    .port_done_i  (port_done),
    .port_rdata_i (port_rdata),
    .bus_o        (bus_req),
    .i_fill_o     (i_fill),
    .d_fill_o     (d_fill),
    .inst_stall_o (inst_stall_o),
    .data_stall_o (data_stall_o)
  );

  mem_port u_mem_port (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (bus_req),
    .mem_o       (mem_o),
    .mem_rdata_i (mem_rdata_i),
    .mem_ack_i   (mem_ack_i),
    .done_o      (port_done),
    .rdata_o     (port_rdata)
  );

endmodule

`default_nettype wire

/* source/data_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_mem_params.svh"

module data_align (
  input  wire  cpu_mem_pkg::access_e    acc_i,
  input  wire  [1:0]                    addr_lo_i,
  input  wire  [`CM_DATA_W-1:0]         wdata_i,
  input  wire  [`CM_DATA_W-1:0]         raw_i,
  output logic [`CM_DATA_W-1:0]         store_data_o,
  output logic [(`CM_DATA_W/8)-1:0]     be_o,
  output logic [`CM_DATA_W-1:0]         load_data_o
);

  logic [7:0]  load_byte;
  logic [15:0] load_half;

  // store side: replicate into every lane, enables pick the lane
  always_comb begin
    case (acc_i)
      cpu_mem_pkg::ACC_BYTE, cpu_mem_pkg::ACC_BYTE_U: begin
        store_data_o = {4{wdata_i[7:0]}};
        be_o         = 4'b0001 << addr_lo_i;
      end
      cpu_mem_pkg::ACC_HALF, cpu_mem_pkg::ACC_HALF_U: begin
        store_data_o = {2{wdata_i[15:0]}};
        be_o         = addr_lo_i[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_data_o = wdata_i; // full word
        be_o         = 4'b1111;
      end
    endcase
  end

  // load side lane select
  assign load_byte = raw_i[8*addr_lo_i +: 8];
  assign load_half = addr_lo_i[1] ? raw_i[31:16] : raw_i[15:0];

  always_comb begin
    case (acc_i)
      cpu_mem_pkg::ACC_BYTE:   load_data_o = {{24{load_byte[7]}}, load_byte};
      cpu_mem_pkg::ACC_BYTE_U: load_data_o = {24'h0, load_byte};
      cpu_mem_pkg::ACC_HALF:   load_data_o = {{16{load_half[15]}}, load_half};
      cpu_mem_pkg::ACC_HALF_U: load_data_o = {16'h0, load_half};
      default:                 load_data_o = raw_i;
    endcase
  end

endmodule

`default_nettype wire

/* source/mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_mem_params.svh"

module mem_port (
  input  wire                          clk_i,
  input  wire                          rst_n_i,
  input  wire  cpu_mem_pkg::bus_req_t  start_i,
  output cpu_mem_pkg::bus_req_t        mem_o,
  input  wire  [`CM_DATA_W-1:0]        mem_rdata_i,
  input  wire                          mem_ack_i,
  output logic                         done_o,
  output logic [`CM_DATA_W-1:0]        rdata_o
);

  logic                  busy_q; // transaction on the bus
  cpu_mem_pkg::bus_req_t req_q;
  logic                  take;

  // only accept a new request when nothing is outstanding
  assign take = start_i.valid & ~busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (take) begin
      busy_q <= 1'b1;
    end else if (mem_ack_i) begin
      busy_q <= 1'b0; // valid drops the cycle after ack
    end
  end

  // request payload held stable until acknowledged
  always_ff @(posedge clk_i) begin
    if (take) begin
      req_q <= start_i;
    end
  end

  always_comb begin
    mem_o       = req_q;
    mem_o.valid = busy_q;
  end

  // ack finishes the transaction in the same cycle
  assign done_o  = busy_q & mem_ack_i;
  assign rdata_o = mem_rdata_i; // read data valid with the ack

endmodule

`default_nettype wire

/* testbench/tb_cpu_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_mem_params.svh"

module tb_cpu_mem;

  localparam int WAIT_MAX = 50;  // cycles before a stall wait gives up
  localparam int WORDS    = 256; // 1 KB of memory

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   inst_req_i;
  logic [`CM_ADDR_W-1:0]  inst_addr_i;
  logic [`CM_DATA_W-1:0]  inst_rdata_o;
  logic                   inst_stall_o;
  cpu_mem_pkg::core_req_t data_i;
  logic [`CM_DATA_W-1:0]  data_rdata_o;
  logic                   data_stall_o;
  cpu_mem_pkg::bus_req_t  mem_o;
  logic [`CM_DATA_W-1:0]  mem_rdata_i;
  logic                   mem_ack_i;

  logic [31:0] mem    [WORDS]; // bus side memory
  logic [31:0] shadow [WORDS]; // what the core should read
  logic [31:0] bus_log [$];    // bus addresses in ack order
  logic [3:0]  last_be;
  int          errors;
  int          checks;
  int          cyc;
  int          ack_cyc;
  int          done_cyc;
  int          bus_reads;
  int          bus_writes;
  int          bus_wait = -1;

  cpu_mem_top DUT (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .inst_req_i   (inst_req_i),
    .inst_addr_i  (inst_addr_i),
    .inst_rdata_o (inst_rdata_o),
    .inst_stall_o (inst_stall_o),
    .data_i       (data_i),
    .data_rdata_o (data_rdata_o),
    .data_stall_o (data_stall_o),
    .mem_o        (mem_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_ack_i    (mem_ack_i)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  // memory acks after 1 to 4 cycles of valid
  always @(posedge clk_i) begin
    #1;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    if (rst_n_i && mem_o.valid) begin
      if (bus_wait < 0) begin
        bus_wait = $urandom_range(3, 0);
      end
      if (bus_wait == 0) begin
        mem_ack_i   = 1'b1;
        mem_rdata_i = mem[mem_o.addr[9:2]];
        ack_cyc     = cyc;
        last_be     = mem_o.be;
        bus_log.push_back(mem_o.addr);
        if (mem_o.we) begin
          bus_writes++;
          for (int i = 0; i < 4; i++) begin
            if (mem_o.be[i]) begin
              mem[mem_o.addr[9:2]][8*i +: 8] = mem_o.wdata[8*i +: 8];
            end
          end
        end else begin
          bus_reads++;
        end
        bus_wait = -1;
      end else begin
        bus_wait--;
      end
    end
  end

  // expected load value from one shadow word
  function automatic logic [31:0] ref_load(input logic [31:0] word,
                                           input cpu_mem_pkg::access_e acc,
                                           input logic [1:0] off);
    logic [31:0] low;
    low = word >> (8 * off); // addressed byte moved down to bit 0
    case (acc)
      cpu_mem_pkg::ACC_BYTE:   return {{24{low[7]}}, low[7:0]};
      cpu_mem_pkg::ACC_BYTE_U: return {24'h0, low[7:0]};
      cpu_mem_pkg::ACC_HALF:   return {{16{low[15]}}, low[15:0]};
      cpu_mem_pkg::ACC_HALF_U: return {16'h0, low[15:0]};
      default:                 return word;
    endcase
  endfunction

  function automatic logic [3:0] exp_be(input cpu_mem_pkg::access_e acc, input logic [1:0] off);
    logic [3:0] mask;
    case (acc)
      cpu_mem_pkg::ACC_BYTE, cpu_mem_pkg::ACC_BYTE_U: mask = 4'b0001;
      cpu_mem_pkg::ACC_HALF, cpu_mem_pkg::ACC_HALF_U: mask = 4'b0011;
      default:                                        mask = 4'b1111;
    endcase
    return mask << off; // lanes start at the byte offset
  endfunction

  function automatic cpu_mem_pkg::access_e pick_acc(input int n);
    case (n % 5)
      0:       return cpu_mem_pkg::ACC_BYTE;
      1:       return cpu_mem_pkg::ACC_HALF;
      2:       return cpu_mem_pkg::ACC_WORD;
      3:       return cpu_mem_pkg::ACC_BYTE_U;
      default: return cpu_mem_pkg::ACC_HALF_U;
    endcase
  endfunction

  // naturally aligned address in the upper half, kept apart from fetches
  function automatic logic [31:0] data_addr(input cpu_mem_pkg::access_e acc);
    logic [31:0] a;
    a = 32'h200 + ($urandom % 512);
    if (acc == cpu_mem_pkg::ACC_WORD) begin
      a[1:0] = 2'b00;
    end else if (acc == cpu_mem_pkg::ACC_HALF || acc == cpu_mem_pkg::ACC_HALF_U) begin
      a[0] = 1'b0;
    end
    return a;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("error at t=%0t: %s", $time, what);
    end
  endtask

  // samples at negedges until the stall falls or the limit runs out
  task automatic wait_stall(input logic data_side, output int stalls, output logic done);
    stalls = 0;
    @(negedge clk_i);
    while ((data_side ? data_stall_o : inst_stall_o) && stalls < WAIT_MAX) begin
      stalls++;
      @(negedge clk_i);
    end
    done     = !(data_side ? data_stall_o : inst_stall_o);
    done_cyc = cyc;
    check_true(done, $sformatf("%s did not fall within %0d cycles",
                               data_side ? "data_stall_o" : "inst_stall_o", WAIT_MAX));
  endtask

  task automatic fetch(input logic [31:0] addr, output int stalls);
    logic done;
    inst_req_i  = 1'b1;
    inst_addr_i = addr;
    wait_stall(1'b0, stalls, done);
    @(posedge clk_i);
    #1;
    inst_req_i = 1'b0;
  endtask

  task automatic load(input cpu_mem_pkg::access_e acc, input logic [31:0] addr,
                      output int stalls);
    logic done;
    data_i.req  = 1'b1;
    data_i.we   = 1'b0;
    data_i.acc  = acc;
    data_i.addr = addr;
    wait_stall(1'b1, stalls, done);
    @(posedge clk_i);
    #1;
    data_i.req = 1'b0;
  endtask

  task automatic store(input cpu_mem_pkg::access_e acc, input logic [31:0] addr,
                       input logic [31:0] wdata);
    logic [3:0] be;
    logic       done;
    int         stalls;
    int         lane;
    be           = exp_be(acc, addr[1:0]);
    data_i.req   = 1'b1;
    data_i.we    = 1'b1;
    data_i.acc   = acc;
    data_i.addr  = addr;
    data_i.wdata = wdata;
    wait_stall(1'b1, stalls, done);
    @(posedge clk_i); // store completes here
    if (done) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          lane = i - int'(addr[1:0]);
          shadow[addr[9:2]][8*i +: 8] = wdata[8*lane +: 8];
        end
      end
    end
    #1;
    data_i.req = 1'b0;
    data_i.we  = 1'b0;
  endtask

  // every completed read against the shadow memory
  always @(negedge clk_i) begin
    if (rst_n_i && inst_req_i && !inst_stall_o) begin
      check_value("inst_rdata_o", inst_rdata_o,
                  ref_load(shadow[inst_addr_i[9:2]], cpu_mem_pkg::ACC_WORD, 2'b00));
    end
    if (rst_n_i && data_i.req && !data_i.we && !data_stall_o) begin
      check_value("data_rdata_o", data_rdata_o,
                  ref_load(shadow[data_i.addr[9:2]], data_i.acc, data_i.addr[1:0]));
    end
  end

  initial begin
    int                   s_i;
    int                   s_d;
    int                   n_reads;
    int                   n_writes;
    int                   mode;
    logic [31:0]          a;
    logic [31:0]          ia;
    logic [31:0]          wd;
    cpu_mem_pkg::access_e acc;
    void'($urandom(32'h25a6_93cd));
    for (int i = 0; i < WORDS; i++) begin
      mem[i]    = (i * 32'h9e37_79b1) ^ 32'hc3a5_0f1e; // every word differs
      shadow[i] = mem[i];
    end
    rst_n_i     = 1'b0;
    inst_req_i  = 1'b0;
    inst_addr_i = '0;
    data_i      = '0;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_true(!mem_o.valid, "bus request active after reset");
    @(posedge clk_i);
    #1;

    // cold fetches, one bus read each, 2 cycles from ack to stall low
    for (int k = 0; k < 4; k++) begin
      a       = k * 32'h44;
      n_reads = bus_reads;
      bus_log.delete();
      fetch(a, s_i);
      check_true(s_i > 0, "cold fetch did not stall");
      check_value("bus reads", bus_reads, n_reads + 1);
      check_value("mem_o.addr", bus_log[0], a);
      check_value("ack to stall low", done_cyc - ack_cyc, 2);
    end
    // warm fetches
    for (int k = 0; k < 4; k++) begin
      n_reads = bus_reads;
      fetch(k * 32'h44, s_i);
      check_value("inst_stall_o cycles", s_i, 0);
      check_value("bus reads", bus_reads, n_reads);
    end

    // loads of every type at every legal offset
    for (int n = 0; n < 5; n++) begin
      acc = pick_acc(n);
      for (int off = 0; off < 4; off++) begin
        if (!(acc == cpu_mem_pkg::ACC_WORD && off != 0) &&
            !((acc == cpu_mem_pkg::ACC_HALF || acc == cpu_mem_pkg::ACC_HALF_U) && off % 2)) begin
          load(acc, 32'h200 + 4 * n + off, s_d);
        end
      end
    end

    // store hit on a cached line, then read back without the bus
    load(cpu_mem_pkg::ACC_WORD, 32'h200, s_d);
    n_writes = bus_writes;
    bus_log.delete();
    store(cpu_mem_pkg::ACC_BYTE, 32'h201, 32'h0000_00a5);
    check_value("bus writes", bus_writes, n_writes + 1);
    check_value("mem_o.addr", bus_log[0], 32'h200);
    check_value("mem_o.be", last_be, 4'b0010);
    n_reads = bus_reads;
    load(cpu_mem_pkg::ACC_WORD, 32'h200, s_d);
    check_value("data_stall_o cycles", s_d, 0);
    check_value("bus reads", bus_reads, n_reads);
    // store miss goes to memory only
    bus_log.delete();
    store(cpu_mem_pkg::ACC_HALF, 32'h3f2, 32'h1234_beef);
    check_value("mem_o.addr", bus_log[0], 32'h3f0);
    check_value("mem_o.be", last_be, 4'b1100);
    n_reads = bus_reads;
    load(cpu_mem_pkg::ACC_WORD, 32'h3f0, s_d);
    check_value("bus reads", bus_reads, n_reads + 1);

    // I and D miss together, I side first
    bus_log.delete();
    fork
      fetch(32'h1f0, s_i);
      load(cpu_mem_pkg::ACC_WORD, 32'h300, s_d);
    join
    check_value("bus transactions", bus_log.size(), 2);
    check_value("mem_o.addr", bus_log[0], 32'h1f0);
    check_value("mem_o.addr", bus_log[1], 32'h300);

    // random mixed traffic
    for (int k = 0; k < 300; k++) begin
      acc  = pick_acc($urandom % 5);
      a    = data_addr(acc);
      ia   = ($urandom % 128) << 2;
      wd   = $urandom;
      mode = $urandom % 5;
      case (mode)
        0: fetch(ia, s_i);
        1: load(acc, a, s_d);
        2: store(acc, a, wd);
        3: begin
          fork
            fetch(ia, s_i);
            load(acc, a, s_d);
          join
        end
        default: begin
          fork
            fetch(ia, s_i);
            store(acc, a, wd);
          join
        end
      endcase
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
